// File: dv/lane_buffer_tb.sv
/* testbench for lane_buffer_top, random lanes checked against a reference queue
   covers reset state, lane order, output hold, full-FIFO back-pressure and throughput */
`timescale 1ns/1ps
`default_nettype none

module lane_buffer_tb;

	import stream_pkg::*;
	import mem_pkg::*;

	localparam logic [31:0] SEED = 32'hc4031a78;
	localparam int RANDOM_BLOCKS = 200;
	localparam int STREAM_LANES = 64;
	// lanes the RAM alone can hold
	localparam int FIFO_LANES = LANES_PER_BLOCK * (1 << DEFAULT_FIFO_ADDR_WIDTH);
	localparam int STALL_LIMIT = 4 * FIFO_LANES;
	localparam int STALL_CYCLES = 40;
	localparam int TOTAL_LANES = RANDOM_BLOCKS * LANES_PER_BLOCK + STALL_LIMIT +
		LANES_PER_BLOCK + STREAM_LANES;
	localparam int WATCHDOG_CYCLES = TOTAL_LANES * 40 + 2000;

	logic clk;
	logic reset;
	lane_t in_lane;
	logic in_valid;
	logic in_ready;
	lane_t out_lane;
	logic out_valid;
	logic out_ready;

	// reference model state
	lane_t ref_q[$];
	lane_t exp_lane;
	lane_t held_lane;
	logic stalled;
	int in_count = 0;
	int out_count = 0;
	int tp_outs = 0;
	int guard;
	logic stall_phase;
	logic tp_phase;

	tb_clock_gen #(.PERIOD_NS(20.0)) i_clock (.clk(clk));

	lane_buffer_top #(
		.FIFO_ADDR_WIDTH(DEFAULT_FIFO_ADDR_WIDTH)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.in_lane(in_lane),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_lane(out_lane),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	task automatic fail_value(input string name, input lane_t got, input lane_t exp);
		$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic fail_text(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// offers count lanes, in_valid and out_ready at the given duty cycles in percent
	task automatic offer_lanes(input int count, input int valid_pct, input int ready_pct);
		int sent;
		sent = 0;
		while (sent < count) begin
			@(posedge clk);
			if (in_valid && in_ready) begin
				sent++;
			end
			if (sent == count) begin
				in_valid <= 1'b0;
			end else if (!in_valid || in_ready) begin
				// nothing pending, so a new lane may be chosen
				in_valid <= ($urandom % 100) < valid_pct;
				in_lane <= $urandom;
			end
			out_ready <= ($urandom % 100) < ready_pct;
		end
	endtask

	task automatic wait_drain();
		out_ready <= 1'b1;
		do begin
			@(posedge clk);
		end while (out_count != in_count);
	endtask

	// reference queue, every output transfer must match its head
	always @(posedge clk) begin
		if (!reset && in_valid && in_ready) begin
			ref_q.push_back(in_lane);
			in_count <= in_count + 1;
		end
		if (!reset && out_valid && out_ready) begin
			out_count <= out_count + 1;
			if (tp_phase) begin
				tp_outs <= tp_outs + 1;
			end
			if (ref_q.size() == 0) begin
				fail_text("output transfer while no lane was expected");
			end else begin
				exp_lane = ref_q.pop_front();
				assert (out_lane === exp_lane)
					else fail_value("out_lane", out_lane, exp_lane);
			end
		end
	end

	// a stalled output lane holds until the next edge
	always @(posedge clk) begin
		if (!reset && stalled) begin
			assert (out_valid)
				else fail_value("out_valid", out_valid, 1);
			assert (out_lane === held_lane)
				else fail_value("out_lane", out_lane, held_lane);
		end
		stalled <= !reset && out_valid && !out_ready;
		held_lane <= out_lane;
	end

	// nothing can come out before the first whole block went in
	assert property (@(posedge clk) disable iff (reset)
		in_count < LANES_PER_BLOCK |-> in_ready)
		else fail_value("in_ready", $sampled(in_ready), 1);
	assert property (@(posedge clk) disable iff (reset)
		in_count < LANES_PER_BLOCK |-> !out_valid)
		else fail_value("out_valid", $sampled(out_valid), 0);

	// full FIFO keeps input blocked while the output is stalled
	assert property (@(posedge clk) disable iff (reset)
		stall_phase && !in_ready |=> !in_ready)
		else fail_value("in_ready", $sampled(in_ready), 0);

	// no bubbles at full rate
	assert property (@(posedge clk) disable iff (reset)
		tp_phase && out_valid && tp_outs < STREAM_LANES - 1 |=> out_valid)
		else fail_value("out_valid", $sampled(out_valid), 1);

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		in_valid = 1'b0;
		in_lane = '0;
		out_ready = 1'b0;
		stall_phase = 1'b0;
		tp_phase = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		offer_lanes(RANDOM_BLOCKS * LANES_PER_BLOCK, 60, 50);
		wait_drain();

		// fill everything with the output stalled
		stall_phase <= 1'b1;
		out_ready <= 1'b0;
		in_valid <= 1'b1;
		in_lane <= $urandom;
		guard = 0;
		do begin
			@(posedge clk);
			guard++;
			if (in_ready) begin
				in_lane <= $urandom;
			end
		end while (in_ready && guard < STALL_LIMIT);
		assert (!in_ready)
			else fail_text("in_ready never dropped while out_ready was held low");
		assert (in_count - out_count >= FIFO_LANES)
			else fail_text("input blocked before the FIFO could have filled");
		repeat (STALL_CYCLES) @(posedge clk);
		stall_phase <= 1'b0;
		out_ready <= 1'b1;
		// the held lane plus three more close the block
		offer_lanes(LANES_PER_BLOCK, 100, 100);
		wait_drain();

		tp_phase <= 1'b1;
		offer_lanes(STREAM_LANES, 100, 100);
		wait_drain();
		tp_phase <= 1'b0;

		// idle cycles catch any stray output
		repeat (10) @(posedge clk);
		if (ref_q.size() == 0 && in_count == out_count) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("lanes still expected at the end of the run");
			$display("TESTS FAILED");
			$fatal(1, "run stopped with lanes missing");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before all lanes came out");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
/* free-running clock for the lane buffer testbench
   PERIOD_NS sets the period, the first edge is a rising one half a period in */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS = 20.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: files.f
logic/stream_pkg.sv
logic/mem_pkg.sv
logic/block_ram.sv
logic/bram_fifo.sv
logic/lane_packer.sv
logic/lane_unpacker.sv
logic/lane_buffer_top.sv
dv/tb_clock_gen.sv
dv/lane_buffer_tb.sv

// File: logic/block_ram.sv
/* single-clock RAM with one write port and one registered read port
   read data shows up one cycle after the address is presented */
`timescale 1ns/1ps
`default_nettype none

module block_ram #(
	parameter int ADDR_WIDTH = 2,
	parameter int DATA_WIDTH = 128
) (
	input  logic                  clk,
	input  logic                  w_e,
	input  logic [ADDR_WIDTH-1:0] w_addr,
	input  logic [DATA_WIDTH-1:0] w_data,
	input  logic [ADDR_WIDTH-1:0] r_addr,
	output logic [DATA_WIDTH-1:0] r_data
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (w_e) begin
			mem[w_addr] <= w_data;
		end
		// read runs every cycle, old data on a same-address write
		r_data <= mem[r_addr];
	end

endmodule

`default_nettype wire

// File: logic/bram_fifo.sv
/* valid/ready FIFO built on block_ram, concurrent read and write allowed
   a skid register keeps rdata steady while the reader stalls */
`timescale 1ns/1ps
`default_nettype none

module bram_fifo #(
	parameter int ADDR_WIDTH = 2,
	parameter int DATA_WIDTH = stream_pkg::BLOCK_WIDTH
) (
	input  logic                  clk,
	input  logic                  reset,

	// write side
	input  logic [DATA_WIDTH-1:0] wdata,
	input  logic                  write_valid,
	output logic                  write_ready,

	// read side
	output logic [DATA_WIDTH-1:0] rdata,
	output logic                  read_valid,
	input  logic                  read_ready
);

	// one extra bit tells full from empty
	typedef logic [ADDR_WIDTH:0] ptr_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] word_t;

	ptr_t write_ptr;
	ptr_t read_ptr;

	logic write_xfer;
	logic read_xfer;
	logic fifo_empty;
	logic fifo_full;
	logic fetch;

	addr_t ram_r_addr;
	word_t ram_r_data;

	// holds the RAM word once the reader stalls
	word_t skid_data;
	logic skid_valid;

	block_ram #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) i_ram (
		.clk(clk),
		.w_e(write_xfer),
		.w_addr(write_ptr[ADDR_WIDTH-1:0]),
		.w_data(wdata),
		.r_addr(ram_r_addr),
		.r_data(ram_r_data)
	);

	assign fifo_empty = (read_ptr == write_ptr);
	assign fifo_full = (write_ptr[ADDR_WIDTH] != read_ptr[ADDR_WIDTH]) &&
		(write_ptr[ADDR_WIDTH-1:0] == read_ptr[ADDR_WIDTH-1:0]);

	assign write_ready = !fifo_full;
	assign write_xfer = write_valid && write_ready;
	assign read_xfer = read_valid && read_ready;

	// prefetch when the output word is free or leaves this cycle
	assign fetch = !fifo_empty && (!read_valid || read_xfer);

	assign ram_r_addr = read_ptr[ADDR_WIDTH-1:0];

	// RAM output is only good for the cycle after the fetch
	assign rdata = skid_valid ? skid_data : ram_r_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			write_ptr <= '0;
		end else if (write_xfer) begin
			write_ptr <= write_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_ptr <= '0;
		end else if (fetch) begin
			read_ptr <= read_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_valid <= 1'b0;
		end else if (fetch) begin
			read_valid <= 1'b1;
		end else if (read_xfer) begin
			read_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			skid_valid <= 1'b0;
		end else if (read_xfer) begin
			skid_valid <= 1'b0;
		end else if (read_valid && !skid_valid) begin
			// first stalled edge, RAM still shows the fetched word
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (read_valid && !read_ready && !skid_valid) begin
			skid_data <= ram_r_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/lane_buffer_top.sv
/* lane buffer top level, packer into block RAM FIFO into unpacker
   FIFO_ADDR_WIDTH sets the number of buffered blocks */
`timescale 1ns/1ps
`default_nettype none

module lane_buffer_top #(
	parameter int FIFO_ADDR_WIDTH = mem_pkg::DEFAULT_FIFO_ADDR_WIDTH
) (
	input  logic               clk,
	input  logic               reset,
	input  stream_pkg::lane_t  in_lane,
	input  logic               in_valid,
	output logic               in_ready,
	output stream_pkg::lane_t  out_lane,
	output logic               out_valid,
	input  logic               out_ready
);

	import stream_pkg::*;

	// packer to FIFO
	block_t pk_block;
	logic pk_valid;
	logic pk_ready;

	// FIFO to unpacker
	block_t fb_block;
	logic fb_valid;
	logic fb_ready;

	lane_packer i_packer (
		.clk(clk),
		.reset(reset),
		.in_lane(in_lane),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.block(pk_block),
		.block_valid(pk_valid),
		.block_ready(pk_ready)
	);

	bram_fifo #(
		.ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.DATA_WIDTH(BLOCK_WIDTH)
	) i_fifo (
		.clk(clk),
		.reset(reset),
		.wdata(pk_block),
		.write_valid(pk_valid),
		.write_ready(pk_ready),
		.rdata(fb_block),
		.read_valid(fb_valid),
		.read_ready(fb_ready)
	);

	lane_unpacker i_unpacker (
		.clk(clk),
		.reset(reset),
		.block(fb_block),
		.block_valid(fb_valid),
		.block_ready(fb_ready),
		.out_lane(out_lane),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

// File: logic/lane_packer.sv
/* gathers four stream lanes into one block, lane 0 in the low bits
   the finished block is offered downstream with valid/ready */
`timescale 1ns/1ps
`default_nettype none

module lane_packer (
	input  logic                clk,
	input  logic                reset,
	input  stream_pkg::lane_t   in_lane,
	input  logic                in_valid,
	output logic                in_ready,
	output stream_pkg::block_t  block,
	output logic                block_valid,
	input  logic                block_ready
);

	import stream_pkg::*;

	localparam lane_idx_t LAST_LANE = lane_idx_t'(LANES_PER_BLOCK - 1);

	lane_idx_t lane_idx;
	block_t asm_block;
	logic lane_xfer;

	// stall input only while a finished block waits
	assign in_ready = !block_valid || block_ready;
	assign lane_xfer = in_valid && in_ready;

	assign block = asm_block;

	always_ff @(posedge clk) begin
		if (reset) begin
			lane_idx <= '0;
		end else if (lane_xfer) begin
			lane_idx <= lane_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			block_valid <= 1'b0;
		end else begin
			if (block_valid && block_ready) begin
				block_valid <= 1'b0;
			end
			// fourth lane completes the block
			if (lane_xfer && lane_idx == LAST_LANE) begin
				block_valid <= 1'b1;
			end
		end
	end

	// each lane lands in its own slot, nothing shifts
	always_ff @(posedge clk) begin
		if (lane_xfer) begin
			asm_block[lane_idx*LANE_WIDTH +: LANE_WIDTH] <= in_lane;
		end
	end

endmodule

`default_nettype wire

// File: logic/lane_unpacker.sv
/* takes one block at a time and sends out its lanes, lane 0 first
   the next block loads in the cycle that the last lane leaves */
`timescale 1ns/1ps
`default_nettype none

module lane_unpacker (
	input  logic                clk,
	input  logic                reset,
	input  stream_pkg::block_t  block,
	input  logic                block_valid,
	output logic                block_ready,
	output stream_pkg::lane_t   out_lane,
	output logic                out_valid,
	input  logic                out_ready
);

	import stream_pkg::*;

	localparam lane_idx_t LAST_LANE = lane_idx_t'(LANES_PER_BLOCK - 1);

	typedef enum logic [0:0] {
		ST_IDLE,
		ST_EMIT
	} state_t;

	state_t state;
	lane_idx_t lane_idx;
	block_t hold_block;
	logic out_xfer;
	logic load;

	assign out_valid = (state == ST_EMIT);
	assign out_xfer = out_valid && out_ready;

	// free when idle or when the last lane goes out now
	assign block_ready = (state == ST_IDLE) || (out_xfer && lane_idx == LAST_LANE);
	assign load = block_valid && block_ready;

	assign out_lane = hold_block[lane_idx*LANE_WIDTH +: LANE_WIDTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			lane_idx <= '0;
		end else if (load) begin
			state <= ST_EMIT;
			lane_idx <= '0;
		end else if (out_xfer) begin
			lane_idx <= lane_idx + 1'b1;
			if (lane_idx == LAST_LANE) begin
				state <= ST_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			hold_block <= block;
		end
	end

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
/* sizing constants for the block RAM FIFO */
`default_nettype none

package mem_pkg;

	// four RAM entries by default
	// enough to show full-FIFO back-pressure in a short test
	localparam int DEFAULT_FIFO_ADDR_WIDTH = 2;

endpackage

`default_nettype wire

// File: logic/stream_pkg.sv
/* stream and block widths for the lane buffer datapath and its testbench
   import where lanes or packed blocks are handled */
`default_nettype none

package stream_pkg;

	// one lane of the incoming and outgoing stream
	localparam int LANE_WIDTH = 32;

	// lanes packed into one RAM word
	localparam int LANES_PER_BLOCK = 4;

	// width of one packed block, lane 0 in the low bits
	localparam int BLOCK_WIDTH = LANE_WIDTH * LANES_PER_BLOCK;

	typedef logic [LANE_WIDTH-1:0] lane_t;

	typedef logic [BLOCK_WIDTH-1:0] block_t;

	// position of a lane inside a block
	typedef logic [$clog2(LANES_PER_BLOCK)-1:0] lane_idx_t;

endpackage

`default_nettype wire
